//--- source/soc_cfg.svh
// board peripheral configuration
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// ==============================
// register bus widths
// ==============================
`define SOC_DATA_W 8
`define SOC_ADDR_W 4

// address bit splitting
// region bit picks the peripheral, local bit picks the register inside it
`define SOC_REGION_BIT 1
`define SOC_LOCAL_BIT 0

// ==============================
// address map
// ==============================
// uart tx data, write only
`define ADDR_UART_TXDATA 4'h0
// uart status, read only
`define ADDR_UART_STATUS 4'h1
// led register, read and write
`define ADDR_GPIO_LED 4'h2
// dip switches, read only
`define ADDR_GPIO_SW 4'h3

// ==============================
// peripheral sizes
// ==============================
// clocks per serial bit, short for simulation
`define UART_CLKS_PER_BIT 8
`define GPIO_LED_W 8
`define GPIO_SW_W 4

`endif

//--- source/soc_pkg.sv
// board peripheral shared types
`include "soc_cfg.svh"

package soc_pkg;

  // ==============================
  // register bus types
  // ==============================

  // full bus address
  typedef logic [`SOC_ADDR_W-1:0] reg_addr_t;

  // one register data word
  typedef logic [`SOC_DATA_W-1:0] reg_data_t;

  // ==============================
  // uart status word
  // ==============================

  // bit 0 busy, bit 1 overrun
  // upper bits always zero
  typedef struct packed {
    logic [`SOC_DATA_W-3:0] rsvd;
    logic                   overrun;
    logic                   busy;
  } uart_status_t;

endpackage

//--- source/periph_bus_if.sv
// peripheral register port
`timescale 1ns/1ps

interface periph_bus_if;
  import soc_pkg::*;

  // peripheral selected for this access
  logic      sel;
  // write strobe, already qualified by sel
  logic      wr;
  // read strobe, already qualified by sel
  logic      rd;
  // local register select bit
  logic      addr;
  // write data
  reg_data_t wdata;
  // read data, combinational from the peripheral
  reg_data_t rdata;

  // bus multiplexer side
  modport mux (
    output sel,
    output wr,
    output rd,
    output addr,
    output wdata,
    input  rdata
  );

  // peripheral side
  modport periph (
    input  sel,
    input  wr,
    input  rd,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

//--- source/uart_tx.sv
// uart transmitter
`timescale 1ns/1ps
`include "soc_cfg.svh"

module uart_tx #(
  parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
  input  logic         clk,
  input  logic         i_rst_n,
  output logic         o_uart_td,
  periph_bus_if.periph bus
);
  import soc_pkg::*;

  // baud counter needs at least one bit
  localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
  localparam logic [CNT_W-1:0] BAUD_LAST = CNT_W'(CLKS_PER_BIT - 1);
  // start + 8 data + stop, numbered 0..9
  localparam logic [3:0] LAST_BIT = 4'd9;
  localparam reg_addr_t TXDATA_A = `ADDR_UART_TXDATA;
  localparam reg_addr_t STATUS_A = `ADDR_UART_STATUS;

  logic [CNT_W-1:0] baud_cnt;
  logic [3:0]       bit_cnt;
  reg_data_t        tx_shreg;
  logic             busy_q;
  logic             ovr_q;
  logic             td_q;

  logic             wr_txdata;
  logic             rd_status;
  logic             accept;
  logic             baud_end;
  logic             shift_en;
  uart_status_t     status_w;

  // ==============================
  // register strobes
  // ==============================
  assign wr_txdata = bus.sel & bus.wr & (bus.addr == TXDATA_A[`SOC_LOCAL_BIT]);
  assign rd_status = bus.sel & bus.rd & (bus.addr == STATUS_A[`SOC_LOCAL_BIT]);

  // new byte only taken when line is idle
  assign accept = wr_txdata & ~busy_q;

  // last clock of the current bit
  assign baud_end = (baud_cnt == BAUD_LAST);
  // move to the next bit, not past the stop bit
  assign shift_en = busy_q & baud_end & (bit_cnt != LAST_BIT);

  // ==============================
  // frame sequencing
  // ==============================
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      busy_q   <= 1'b0;
      td_q     <= 1'b1;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end else if (accept) begin
      // start bit goes out right away
      busy_q   <= 1'b1;
      td_q     <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end else if (busy_q) begin
      if (baud_end) begin
        baud_cnt <= '0;
        if (bit_cnt == LAST_BIT) begin
          // stop bit done, back to idle
          busy_q <= 1'b0;
          td_q   <= 1'b1;
        end else begin
          td_q    <= tx_shreg[0];
          bit_cnt <= bit_cnt + 4'd1;
        end
      end else begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

  // data shifter, lsb first
  // ones shifted in from the top form the stop bit
  always_ff @(posedge clk) begin
    if (accept) begin
      tx_shreg <= bus.wdata;
    end else if (shift_en) begin
      tx_shreg <= {1'b1, tx_shreg[`SOC_DATA_W-1:1]};
    end
  end

  // ==============================
  // overrun flag
  // ==============================
  // sticky, set by a write during a frame
  // cleared when status is read
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ovr_q <= 1'b0;
    end else if (wr_txdata & busy_q) begin
      ovr_q <= 1'b1;
    end else if (rd_status) begin
      ovr_q <= 1'b0;
    end
  end

  // status word
  always_comb begin
    status_w         = '0;
    status_w.overrun = ovr_q;
    status_w.busy    = busy_q;
  end

  // txdata is write only and reads zero
  assign bus.rdata = (bus.addr == STATUS_A[`SOC_LOCAL_BIT]) ? reg_data_t'(status_w) : '0;

  assign o_uart_td = td_q;

endmodule

//--- source/gpio_ctrl.sv
// gpio leds and switches
`timescale 1ns/1ps
`include "soc_cfg.svh"

module gpio_ctrl (
  input  logic                   clk,
  input  logic                   i_rst_n,
  input  logic [`GPIO_SW_W-1:0]  i_sw,
  output logic [`GPIO_LED_W-1:0] o_led,
  periph_bus_if.periph           bus
);
  import soc_pkg::*;

  localparam reg_addr_t LED_A = `ADDR_GPIO_LED;
  localparam reg_addr_t SW_A  = `ADDR_GPIO_SW;

  // led output register
  logic [`GPIO_LED_W-1:0] led_q;
  // switch synchronizer stages
  logic [`GPIO_SW_W-1:0]  sw_meta;
  logic [`GPIO_SW_W-1:0]  sw_sync;
  logic                   led_wr;

  // ==============================
  // led register
  // ==============================
  // writes to the switch address are ignored
  assign led_wr = bus.sel & bus.wr & (bus.addr == LED_A[`SOC_LOCAL_BIT]);

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      led_q <= '0;
    end else if (led_wr) begin
      led_q <= bus.wdata[`GPIO_LED_W-1:0];
    end
  end

  // leds follow the register directly
  assign o_led = led_q;

  // ==============================
  // switch input
  // ==============================
  // switches are asynchronous to clk
  // two flops before anything reads them
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      sw_meta <= '0;
      sw_sync <= '0;
    end else begin
      sw_meta <= i_sw;
      sw_sync <= sw_meta;
    end
  end

  // ==============================
  // read data
  // ==============================
  // switches zero extended into the data word
  assign bus.rdata = (bus.addr == SW_A[`SOC_LOCAL_BIT]) ? reg_data_t'(sw_sync)
                                                        : reg_data_t'(led_q);

endmodule

//--- source/periph_bus_mux.sv
// register bus multiplexer
`timescale 1ns/1ps
`include "soc_cfg.svh"

module periph_bus_mux (
  input  logic               clk,
  input  logic               i_rst_n,
  input  logic               i_bus_wr,
  input  logic               i_bus_rd,
  input  soc_pkg::reg_addr_t i_bus_addr,
  input  soc_pkg::reg_data_t i_bus_wdata,
  output soc_pkg::reg_data_t o_bus_rdata,
  output logic               o_bus_rvalid,
  periph_bus_if.mux          uart_bus,
  periph_bus_if.mux          gpio_bus
);
  import soc_pkg::*;

  logic      mapped;
  logic      region_gpio;
  logic      uart_sel;
  logic      gpio_sel;
  logic      local_bit;
  reg_data_t rd_mux;

  // ==============================
  // address decode
  // ==============================
  // everything above the region bit must be zero
  assign mapped      = (i_bus_addr[`SOC_ADDR_W-1:`SOC_REGION_BIT+1] == '0);
  // region 0 uart, region 1 gpio
  assign region_gpio = i_bus_addr[`SOC_REGION_BIT];
  assign uart_sel    = mapped & ~region_gpio;
  assign gpio_sel    = mapped & region_gpio;
  // register inside the peripheral is its own business
  assign local_bit   = i_bus_addr[`SOC_LOCAL_BIT];

  // uart port
  assign uart_bus.sel   = uart_sel;
  assign uart_bus.wr    = i_bus_wr & uart_sel;
  assign uart_bus.rd    = i_bus_rd & uart_sel;
  assign uart_bus.addr  = local_bit;
  assign uart_bus.wdata = i_bus_wdata;

  // gpio port
  assign gpio_bus.sel   = gpio_sel;
  assign gpio_bus.wr    = i_bus_wr & gpio_sel;
  assign gpio_bus.rd    = i_bus_rd & gpio_sel;
  assign gpio_bus.addr  = local_bit;
  assign gpio_bus.wdata = i_bus_wdata;

  // ==============================
  // read return
  // ==============================
  // unmapped reads give zero
  always_comb begin
    rd_mux = '0;
    if (uart_sel) begin
      rd_mux = uart_bus.rdata;
    end else if (gpio_sel) begin
      rd_mux = gpio_bus.rdata;
    end
  end

  // one cycle read latency
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_bus_rvalid <= 1'b0;
    end else begin
      o_bus_rvalid <= i_bus_rd;
    end
  end

  // data only meaningful while rvalid is high
  always_ff @(posedge clk) begin
    if (i_bus_rd) begin
      o_bus_rdata <= rd_mux;
    end
  end

endmodule

//--- source/board_top.sv
// board peripheral top
`timescale 1ns/1ps
`include "soc_cfg.svh"

module board_top (
  input  logic                   clk,
  input  logic                   i_rst_n,
  // external register bus
  input  logic                   i_bus_wr,
  input  logic                   i_bus_rd,
  input  soc_pkg::reg_addr_t     i_bus_addr,
  input  soc_pkg::reg_data_t     i_bus_wdata,
  output soc_pkg::reg_data_t     o_bus_rdata,
  output logic                   o_bus_rvalid,
  // board pins
  input  logic [`GPIO_SW_W-1:0]  i_sw,
  output logic                   o_uart_td,
  output logic [`GPIO_LED_W-1:0] o_led
);

  // ==============================
  // peripheral ports
  // ==============================
  periph_bus_if uart_if ();
  periph_bus_if gpio_if ();

  // decode and read merge
  periph_bus_mux bus_mux0 (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_bus_wr     (i_bus_wr),
    .i_bus_rd     (i_bus_rd),
    .i_bus_addr   (i_bus_addr),
    .i_bus_wdata  (i_bus_wdata),
    .o_bus_rdata  (o_bus_rdata),
    .o_bus_rvalid (o_bus_rvalid),
    .uart_bus     (uart_if.mux),
    .gpio_bus     (gpio_if.mux)
  );

  // ==============================
  // peripherals
  // ==============================
  // serial transmit line
  uart_tx #(
    .CLKS_PER_BIT (`UART_CLKS_PER_BIT)
  ) uart_tx0 (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .o_uart_td (o_uart_td),
    .bus       (uart_if.periph)
  );

  // leds and dip switches
  gpio_ctrl gpio0 (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_sw    (i_sw),
    .o_led   (o_led),
    .bus     (gpio_if.periph)
  );

endmodule

//--- testbench/board_top_tb.sv
// board top testbench
`timescale 1ns/1ps
`include "soc_cfg.svh"

module board_top_tb;
  import soc_pkg::*;

  // ==============================
  // constants
  // ==============================
  localparam int CLKS       = `UART_CLKS_PER_BIT;
  localparam int FRAME_CLKS = 10 * CLKS;
  // bound for any single wait loop
  localparam int WAIT_MAX   = 4 * FRAME_CLKS;

  localparam reg_addr_t A_TXDATA = `ADDR_UART_TXDATA;
  localparam reg_addr_t A_STATUS = `ADDR_UART_STATUS;
  localparam reg_addr_t A_LED    = `ADDR_GPIO_LED;
  localparam reg_addr_t A_SW     = `ADDR_GPIO_SW;

  // status words, busy is bit 0, overrun is bit 1
  localparam reg_data_t ST_IDLE     = 8'h00;
  localparam reg_data_t ST_BUSY     = 8'h01;
  localparam reg_data_t ST_BUSY_OVR = 8'h03;

  logic                   clk;
  logic                   rst_n;
  logic                   bus_wr;
  logic                   bus_rd;
  reg_addr_t              bus_addr;
  reg_data_t              bus_wdata;
  reg_data_t              bus_rdata;
  logic                   bus_rvalid;
  logic [`GPIO_SW_W-1:0]  sw;
  logic                   uart_td;
  logic [`GPIO_LED_W-1:0] led;

  int          errors;
  int          checks;
  logic [31:0] rng_state;
  string       cur_test;

  board_top dut0 (
    .clk          (clk),
    .i_rst_n      (rst_n),
    .i_bus_wr     (bus_wr),
    .i_bus_rd     (bus_rd),
    .i_bus_addr   (bus_addr),
    .i_bus_wdata  (bus_wdata),
    .o_bus_rdata  (bus_rdata),
    .o_bus_rvalid (bus_rvalid),
    .i_sw         (sw),
    .o_uart_td    (uart_td),
    .o_led        (led)
  );

  // 10 ns clock
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ==============================
  // helpers
  // ==============================
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic compare_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("ERR %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("%s: %s", cur_test, msg);
    errors++;
  endtask

  // strobe sampled at the edge after the drive
  task automatic bus_write(input reg_addr_t addr, input reg_data_t data);
    @(posedge clk);
    #1;
    bus_wr    = 1'b1;
    bus_addr  = addr;
    bus_wdata = data;
    @(posedge clk);
    #1;
    bus_wr = 1'b0;
  endtask

  // rvalid expected at the first negedge after the sampling edge
  task automatic bus_read(input reg_addr_t addr, output reg_data_t data);
    int   waited;
    logic found;
    waited = 0;
    found  = 1'b0;
    data   = '0;
    @(posedge clk);
    #1;
    bus_rd   = 1'b1;
    bus_addr = addr;
    @(posedge clk);
    #1;
    bus_rd = 1'b0;
    while (!found && waited < WAIT_MAX) begin
      @(negedge clk);
      waited++;
      if (bus_rvalid) begin
        found = 1'b1;
        data  = bus_rdata;
      end
    end
    assert (found) else report_failure("read valid never came after a read strobe");
    if (found) begin
      compare_value("read latency", 1, waited);
      // pulse is one cycle wide
      @(negedge clk);
      compare_value("rvalid width", 0, bus_rvalid);
    end
  endtask

  task automatic read_expect(input reg_addr_t addr, input reg_data_t exp, input string what);
    reg_data_t data;
    bus_read(addr, data);
    compare_value(what, exp, data);
  endtask

  // samples each bit at its centre on falling clock edges
  task automatic uart_capture(output reg_data_t data);
    int   waited;
    logic found;
    waited = 0;
    found  = 1'b0;
    data   = '0;
    while (!found && waited < WAIT_MAX) begin
      @(negedge clk);
      waited++;
      if (!uart_td) begin
        found = 1'b1;
      end
    end
    assert (found) else report_failure("no start bit seen on the serial line");
    if (found) begin
      // middle of the start bit
      repeat (CLKS / 2) @(negedge clk);
      compare_value("start bit", 0, uart_td);
      // lsb first
      for (int i = 0; i < 8; i++) begin
        repeat (CLKS) @(negedge clk);
        data[i] = uart_td;
      end
      repeat (CLKS) @(negedge clk);
      compare_value("stop bit", 1, uart_td);
    end
  endtask

  // ==============================
  // tests
  // ==============================
  task automatic reset_defaults();
    cur_test = "reset_defaults";
    compare_value("uart line", 1, uart_td);
    compare_value("led", 0, led);
    // idle bus, no stray rvalid
    repeat (5) begin
      @(negedge clk);
      compare_value("idle rvalid", 0, bus_rvalid);
    end
    read_expect(A_STATUS, ST_IDLE, "status");
  endtask

  task automatic led_register_rw();
    logic [31:0] r;
    reg_data_t   v;
    cur_test = "led_register_rw";
    repeat (4) begin
      r = next_rand();
      v = r[7:0];
      bus_write(A_LED, v);
      // leds change at the write edge
      compare_value("led pins", v, led);
      read_expect(A_LED, v, "led readback");
    end
  endtask

  task automatic switch_sampling();
    logic [31:0]           r;
    logic [`GPIO_SW_W-1:0] s;
    reg_data_t             data;
    cur_test = "switch_sampling";
    repeat (4) begin
      r = next_rand();
      s = r[`GPIO_SW_W-1:0];
      @(posedge clk);
      #1;
      sw = s;
      // two sync flops plus margin
      repeat (3) @(posedge clk);
      bus_read(A_SW, data);
      compare_value("switch value", s, data[`GPIO_SW_W-1:0]);
    end
  endtask

  task automatic uart_frames();
    logic [31:0] r;
    reg_data_t   b;
    reg_data_t   got;
    reg_data_t   st;
    cur_test = "uart_frames";
    repeat (3) begin
      r = next_rand();
      b = r[7:0];
      bus_write(A_TXDATA, b);
      fork
        uart_capture(got);
        begin
          // somewhere inside the frame
          repeat (3 * CLKS) @(posedge clk);
          bus_read(A_STATUS, st);
          compare_value("status in frame", ST_BUSY, st);
        end
      join
      compare_value("tx byte", b, got);
      // capture ends mid stop bit, let the frame finish
      repeat (CLKS / 2) @(posedge clk);
      read_expect(A_STATUS, ST_IDLE, "status after frame");
    end
  endtask

  task automatic uart_overrun();
    logic [31:0] r;
    reg_data_t   first;
    reg_data_t   second;
    reg_data_t   got;
    reg_data_t   st;
    logic        line_quiet;
    cur_test = "uart_overrun";
    r      = next_rand();
    first  = r[7:0];
    r      = next_rand();
    second = r[7:0];
    @(posedge clk);
    #1;
    bus_wr    = 1'b1;
    bus_addr  = A_TXDATA;
    bus_wdata = first;
    fork
      uart_capture(got);
      begin
        // second write lands while busy
        @(posedge clk);
        #1;
        bus_wdata = second;
        @(posedge clk);
        #1;
        bus_wr = 1'b0;
        repeat (2 * CLKS) @(posedge clk);
        bus_read(A_STATUS, st);
        compare_value("status overrun set", ST_BUSY_OVR, st);
        // previous read cleared the flag
        bus_read(A_STATUS, st);
        compare_value("status overrun cleared", ST_BUSY, st);
      end
    join
    compare_value("tx byte", first, got);
    // dropped byte must not start another frame
    line_quiet = 1'b1;
    repeat (FRAME_CLKS) begin
      @(negedge clk);
      if (!uart_td) begin
        line_quiet = 1'b0;
      end
    end
    checks++;
    assert (line_quiet) else report_failure("a second frame started after a dropped write");
    read_expect(A_STATUS, ST_IDLE, "status after frame");
  endtask

  task automatic decode_and_latency();
    logic [31:0] r;
    reg_data_t   v;
    cur_test = "decode_and_latency";
    // unmapped and write only addresses read zero
    read_expect(reg_addr_t'(4'h4), '0, "unmapped 4");
    read_expect(reg_addr_t'(4'h7), '0, "unmapped 7");
    read_expect(reg_addr_t'(4'h9), '0, "unmapped 9");
    read_expect(reg_addr_t'(4'hf), '0, "unmapped f");
    read_expect(A_TXDATA, '0, "txdata read");
    r = next_rand();
    v = r[7:0];
    bus_write(A_LED, v);
    // back to back, sampled just after each edge
    @(posedge clk);
    #1;
    bus_rd   = 1'b1;
    bus_addr = A_LED;
    @(posedge clk);
    #1;
    bus_addr = A_SW;
    compare_value("first rvalid", 1, bus_rvalid);
    compare_value("first rdata led", v, bus_rdata);
    @(posedge clk);
    #1;
    bus_rd = 1'b0;
    compare_value("second rvalid", 1, bus_rvalid);
    compare_value("second rdata sw", sw, bus_rdata[`GPIO_SW_W-1:0]);
    @(posedge clk);
    #1;
    compare_value("rvalid after burst", 0, bus_rvalid);
  endtask

  // ==============================
  // main sequence
  // ==============================
  initial begin
    errors    = 0;
    checks    = 0;
    rng_state = 32'd46120;
    cur_test  = "init";
    rst_n     = 1'b0;
    bus_wr    = 1'b0;
    bus_rd    = 1'b0;
    bus_addr  = '0;
    bus_wdata = '0;
    sw        = '0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;

    reset_defaults();
    led_register_rw();
    switch_sampling();
    uart_frames();
    uart_overrun();
    decode_and_latency();

    repeat (4) @(posedge clk);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+source
source/soc_pkg.sv
source/periph_bus_if.sv
source/uart_tx.sv
source/gpio_ctrl.sv
source/periph_bus_mux.sv
source/board_top.sv
testbench/board_top_tb.sv
